/* files.f */
+incdir+src
src/cpu_pkg.sv
src/instruction_fetch.sv
src/ir_controller.sv
src/register_file.sv
src/operand_select.sv
src/alu.sv
src/cpu_core.sv
verification/clock_gen.sv
verification/cpu_core_props.sv
verification/cpu_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the cpu_core testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module cpu_core_tb -f files.f \
  -o cpu_core_sim > build.log 2>&1 \
  && ./obj_dir/cpu_core_sim > sim.log 2>&1 \
  || { cat build.log; }

cat sim.log 2> /dev/null

grep -qx "PASS: all tests" sim.log && echo "result: passed" \
  || { echo "result: failed"; exit 1; }

/* src/alu.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
  input  logic                   clock,
  input  cpu_pkg::ctrl_t         ctrl,
  input  cpu_pkg::opcode_e       opcode,
  input  cpu_pkg::sub_opcode_e   sub_opcode,
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  output logic [`CPU_DATA_W-1:0] result
);

  logic [4:0]               shamt;
  logic [2*`CPU_DATA_W-1:0] rot_wide;
  logic [`CPU_DATA_W-1:0]   result_next;

  // shift amount is the zero-extended imm5
  assign shamt = b[4:0];

  // rotate right via a doubled word
  assign rot_wide = {a, a} >> shamt;

  always_comb begin
    result_next = '0;
    case (opcode)
      cpu_pkg::TYPE_BASIC: begin
        case (sub_opcode)
          cpu_pkg::ADD:   result_next = a + b;
          cpu_pkg::SUB:   result_next = a - b;
          cpu_pkg::AND:   result_next = a & b;
          cpu_pkg::OR:    result_next = a | b;
          cpu_pkg::XOR:   result_next = a ^ b;
          cpu_pkg::SLLI:  result_next = a << shamt;
          cpu_pkg::SRLI:  result_next = a >> shamt;
          cpu_pkg::ROTRI: result_next = rot_wide[`CPU_DATA_W-1:0];
          default:        result_next = '0;
        endcase
      end
      cpu_pkg::ADDI: result_next = a + b;
      cpu_pkg::ORI:  result_next = a | b;
      cpu_pkg::XORI: result_next = a ^ b;
      default:       result_next = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (ctrl.alu_execute) begin
      result <= result_next;
    end
  end

endmodule

/* src/cpu_core.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core (
  input  logic              clock,
  input  logic              reset,
  input  cpu_pkg::im_load_t load,
  output cpu_pkg::retire_t  retire
);

  logic [`CPU_IM_AW-1:0]  pc;
  logic [`CPU_DATA_W-1:0] instr;
  logic                   pc_advance;
  cpu_pkg::ctrl_t         ctrl;
  cpu_pkg::opcode_e       opcode;
  cpu_pkg::sub_opcode_e   sub_opcode;
  logic [`CPU_REG_AW-1:0] ra;
  logic [`CPU_REG_AW-1:0] rb;
  logic [`CPU_REG_AW-1:0] rd;
  logic [4:0]             imm5;
  logic [14:0]            imm15;
  logic [19:0]            imm20;
  logic [`CPU_DATA_W-1:0] src1;
  logic [`CPU_DATA_W-1:0] src2;
  logic [`CPU_DATA_W-1:0] operand_b;
  logic [`CPU_DATA_W-1:0] imm_value;
  logic [`CPU_DATA_W-1:0] alu_result;

  instruction_fetch instruction_fetch_inst (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .pc_advance (pc_advance),
    .pc         (pc),
    .instr      (instr)
  );

  ir_controller ir_controller_inst (
    .clock      (clock),
    .reset      (reset),
    .instr      (instr),
    .pc         (pc),
    .alu_result (alu_result),
    .imm_value  (imm_value),
    .ctrl       (ctrl),
    .opcode     (opcode),
    .sub_opcode (sub_opcode),
    .ra         (ra),
    .rb         (rb),
    .rd         (rd),
    .imm5       (imm5),
    .imm15      (imm15),
    .imm20      (imm20),
    .pc_advance (pc_advance),
    .retire     (retire)
  );

  // write data is the retired value
  register_file register_file_inst (
    .clock (clock),
    .ctrl  (ctrl),
    .ra    (ra),
    .rb    (rb),
    .rd    (rd),
    .wdata (retire.value),
    .src1  (src1),
    .src2  (src2)
  );

  operand_select operand_select_inst (
    .ctrl      (ctrl),
    .src2      (src2),
    .imm5      (imm5),
    .imm15     (imm15),
    .imm20     (imm20),
    .operand_b (operand_b),
    .imm_value (imm_value)
  );

  alu alu_inst (
    .clock      (clock),
    .ctrl       (ctrl),
    .opcode     (opcode),
    .sub_opcode (sub_opcode),
    .a          (src1),
    .b          (operand_b),
    .result     (alu_result)
  );

endmodule

/* src/cpu_pkg.sv */
`include "cpu_settings.svh"

package cpu_pkg;

  // major opcode, instruction bits 30:25
  typedef enum logic [5:0] {
    TYPE_BASIC = 6'b100000,
    ADDI       = 6'b101000,
    ORI        = 6'b101100,
    XORI       = 6'b101011,
    MOVI       = 6'b100010
  } opcode_e;

  // sub-opcode of the basic group, bits 4:0
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } sub_opcode_e;

  typedef enum logic [1:0] {
    STOP  = 2'b00,
    FETCH = 2'b01,
    EXE   = 2'b10,
    WRITE = 2'b11
  } ctrl_state_e;

  // immediate width and extension
  typedef enum logic [1:0] {
    IMM5_ZE  = 2'b00,
    IMM15_SE = 2'b01,
    IMM15_ZE = 2'b10,
    IMM20_SE = 2'b11
  } imm_sel_e;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_IM_AW-1:0]  addr;
    logic [`CPU_DATA_W-1:0] data;
  } im_load_t;

  typedef struct packed {
    logic     reg_read;
    logic     alu_execute;
    logic     reg_write;
    imm_sel_e imm_sel;
    logic     use_imm;
    logic     wb_src2;
  } ctrl_t;

  typedef struct packed {
    logic                   valid;
    logic [`CPU_IM_AW-1:0]  pc;
    logic [`CPU_REG_AW-1:0] rd;
    logic [`CPU_DATA_W-1:0] value;
  } retire_t;

endpackage

/* src/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and instruction word width
`define CPU_DATA_W 32

// register address width, 32 registers
`define CPU_REG_AW 5

// instruction memory address width in words
`define CPU_IM_AW 10

`endif

/* src/instruction_fetch.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instruction_fetch (
  input  logic                   clock,
  input  logic                   reset,
  input  cpu_pkg::im_load_t      load,
  input  logic                   pc_advance,
  output logic [`CPU_IM_AW-1:0]  pc,
  output logic [`CPU_DATA_W-1:0] instr
);

  localparam int IM_DEPTH = 1 << `CPU_IM_AW;

  logic [`CPU_DATA_W-1:0] mem [IM_DEPTH];

  // program load port, word addressed
  always_ff @(posedge clock) begin
    if (load.valid) begin
      mem[load.addr] <= load.data;
    end
    instr <= mem[pc];
  end

  // wraps at the memory depth
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_advance) begin
      pc <= pc + 1'b1;
    end
  end

endmodule

/* src/ir_controller.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module ir_controller (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [`CPU_DATA_W-1:0] instr,
  input  logic [`CPU_IM_AW-1:0]  pc,
  input  logic [`CPU_DATA_W-1:0] alu_result,
  input  logic [`CPU_DATA_W-1:0] imm_value,
  output cpu_pkg::ctrl_t         ctrl,
  output cpu_pkg::opcode_e       opcode,
  output cpu_pkg::sub_opcode_e   sub_opcode,
  output logic [`CPU_REG_AW-1:0] ra,
  output logic [`CPU_REG_AW-1:0] rb,
  output logic [`CPU_REG_AW-1:0] rd,
  output logic [4:0]             imm5,
  output logic [14:0]            imm15,
  output logic [19:0]            imm20,
  output logic                   pc_advance,
  output cpu_pkg::retire_t       retire
);

  cpu_pkg::ctrl_state_e   state;
  cpu_pkg::ctrl_state_e   state_next;
  logic [`CPU_DATA_W-1:0] ir;
  logic [`CPU_DATA_W-1:0] cur;
  logic                   valid_op;
  logic                   is_nop;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= cpu_pkg::STOP;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      cpu_pkg::STOP:  state_next = cpu_pkg::FETCH;
      cpu_pkg::FETCH: state_next = cpu_pkg::EXE;
      cpu_pkg::EXE:   state_next = cpu_pkg::WRITE;
      default:        state_next = cpu_pkg::STOP;
    endcase
  end

  always_ff @(posedge clock) begin
    if (state == cpu_pkg::FETCH) begin
      ir <= instr;
    end
  end

  // register reads happen in fetch, before ir holds the new word
  assign cur = (state == cpu_pkg::FETCH) ? instr : ir;

  assign opcode     = cpu_pkg::opcode_e'(cur[30:25]);
  assign sub_opcode = cpu_pkg::sub_opcode_e'(cur[4:0]);
  assign rd         = cur[24:20];
  assign ra         = cur[19:15];
  assign rb         = cur[14:10];
  assign imm5       = cur[14:10];
  assign imm15      = cur[14:0];
  assign imm20      = cur[19:0];

  // srli by zero is the nop encoding
  assign is_nop = (opcode == cpu_pkg::TYPE_BASIC) && (sub_opcode == cpu_pkg::SRLI) &&
                  (imm5 == 5'd0);

  always_comb begin
    ctrl.imm_sel = cpu_pkg::IMM5_ZE;
    ctrl.use_imm = 1'b0;
    valid_op     = 1'b0;
    case (opcode)
      cpu_pkg::TYPE_BASIC: begin
        case (sub_opcode)
          cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::AND, cpu_pkg::OR, cpu_pkg::XOR: begin
            valid_op = 1'b1;
          end
          cpu_pkg::SLLI, cpu_pkg::SRLI, cpu_pkg::ROTRI: begin
            valid_op     = 1'b1;
            ctrl.use_imm = 1'b1;
          end
          default: valid_op = 1'b0;
        endcase
      end
      cpu_pkg::ADDI: begin
        valid_op     = 1'b1;
        ctrl.imm_sel = cpu_pkg::IMM15_SE;
        ctrl.use_imm = 1'b1;
      end
      cpu_pkg::ORI, cpu_pkg::XORI: begin
        valid_op     = 1'b1;
        ctrl.imm_sel = cpu_pkg::IMM15_ZE;
        ctrl.use_imm = 1'b1;
      end
      cpu_pkg::MOVI: begin
        valid_op     = 1'b1;
        ctrl.imm_sel = cpu_pkg::IMM20_SE;
        ctrl.use_imm = 1'b1;
      end
      default: valid_op = 1'b0;
    endcase
    ctrl.wb_src2     = (opcode == cpu_pkg::MOVI);
    ctrl.reg_read    = (state == cpu_pkg::FETCH);
    ctrl.alu_execute = (state == cpu_pkg::EXE);
    ctrl.reg_write   = (state == cpu_pkg::WRITE) && valid_op && !is_nop;
  end

  assign pc_advance = (state == cpu_pkg::WRITE);

  // report the writeback as it happens
  always_comb begin
    retire.valid = ctrl.reg_write;
    retire.pc    = pc;
    retire.rd    = rd;
    retire.value = ctrl.wb_src2 ? imm_value : alu_result;
  end

endmodule

/* src/operand_select.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module operand_select (
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_DATA_W-1:0] src2,
  input  logic [4:0]             imm5,
  input  logic [14:0]            imm15,
  input  logic [19:0]            imm20,
  output logic [`CPU_DATA_W-1:0] operand_b,
  output logic [`CPU_DATA_W-1:0] imm_value
);

  // extend the selected immediate to full width
  always_comb begin
    case (ctrl.imm_sel)
      cpu_pkg::IMM5_ZE: begin
        imm_value = {{(`CPU_DATA_W-5){1'b0}}, imm5};
      end
      cpu_pkg::IMM15_SE: begin
        imm_value = {{(`CPU_DATA_W-15){imm15[14]}}, imm15};
      end
      cpu_pkg::IMM15_ZE: begin
        imm_value = {{(`CPU_DATA_W-15){1'b0}}, imm15};
      end
      cpu_pkg::IMM20_SE: begin
        imm_value = {{(`CPU_DATA_W-20){imm20[19]}}, imm20};
      end
      default: begin
        imm_value = '0;
      end
    endcase
  end

  // register or immediate second operand
  assign operand_b = ctrl.use_imm ? imm_value : src2;

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
  input  logic                   clock,
  input  cpu_pkg::ctrl_t         ctrl,
  input  logic [`CPU_REG_AW-1:0] ra,
  input  logic [`CPU_REG_AW-1:0] rb,
  input  logic [`CPU_REG_AW-1:0] rd,
  input  logic [`CPU_DATA_W-1:0] wdata,
  output logic [`CPU_DATA_W-1:0] src1,
  output logic [`CPU_DATA_W-1:0] src2
);

  localparam int NUM_REGS = 1 << `CPU_REG_AW;

  // r0 is not hardwired
  logic [`CPU_DATA_W-1:0] regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (ctrl.reg_read) begin
      src1 <= regs[ra];
      src2 <= regs[rb];
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.reg_write) begin
      regs[rd] <= wdata;
    end
  end

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  // 40 ns period
  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // released on a falling edge after 8 cycles
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

/* verification/cpu_core_props.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_props (
  input logic             clock,
  input logic             reset,
  input cpu_pkg::retire_t retire
);

  logic [1:0]            since_reset;
  logic [1:0]            gap;
  logic                  seen;
  logic [`CPU_IM_AW-1:0] last_pc;

  // saturates at 3, the write cycle of the first instruction
  always_ff @(posedge clock) begin
    if (reset) begin
      since_reset <= '0;
    end else if (since_reset != 2'd3) begin
      since_reset <= since_reset + 1'b1;
    end
  end

  // cycles since the last retirement, modulo 4
  always_ff @(posedge clock) begin
    if (reset) begin
      gap     <= '0;
      seen    <= 1'b0;
      last_pc <= '0;
    end else if (retire.valid) begin
      gap     <= '0;
      seen    <= 1'b1;
      last_pc <= retire.pc;
    end else begin
      gap <= gap + 1'b1;
    end
  end

  no_early_retire: assert property (@(posedge clock)
    (since_reset != 2'd3) |-> !retire.valid)
    else $error("retirement during reset or in the first three cycles after it");

  retire_spacing: assert property (@(posedge clock)
    (retire.valid && seen) |-> (gap == 2'd3))
    else $error("two retirements are not a multiple of four cycles apart");

  retire_order: assert property (@(posedge clock)
    (retire.valid && seen) |-> (retire.pc > last_pc))
    else $error("retire pc did not increase since the previous retirement");

endmodule

/* verification/cpu_core_tb.sv */
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core_tb;

  localparam int N_INIT   = 32;
  localparam int N_RAND   = 40;
  localparam int N_FIXED  = 19;
  localparam int PROG_LEN = N_INIT + N_RAND + N_FIXED;

  logic                   clock;
  logic                   reset;
  cpu_pkg::im_load_t      load;
  cpu_pkg::retire_t       retire;
  cpu_pkg::retire_t       head;
  logic [`CPU_DATA_W-1:0] prog [$];
  cpu_pkg::retire_t       expected [$];
  logic [`CPU_DATA_W-1:0] model_regs [32];
  logic [`CPU_IM_AW-1:0]  model_pc;
  logic [`CPU_IM_AW-1:0]  load_addr;
  logic [31:0]            rnd;
  integer                 seed;

  clock_gen clock_gen_inst (
    .clock (clock),
    .reset (reset)
  );

  cpu_core cpu_core_inst (
    .clock  (clock),
    .reset  (reset),
    .load   (load),
    .retire (retire)
  );

  bind cpu_core cpu_core_props cpu_core_props_inst (
    .clock  (clock),
    .reset  (reset),
    .retire (retire)
  );

  function automatic logic [31:0] basic_word(input logic [4:0] sub, input logic [4:0] rd,
                                             input logic [4:0] ra, input logic [4:0] rb);
    return {1'b0, cpu_pkg::TYPE_BASIC, rd, ra, rb, 5'd0, sub};
  endfunction

  function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] ra, input logic [14:0] imm);
    return {1'b0, op, rd, ra, imm};
  endfunction

  function automatic logic [31:0] movi_word(input logic [4:0] rd, input logic [19:0] imm);
    return {1'b0, cpu_pkg::MOVI, rd, imm};
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("MISMATCH %s: got %h expected %h", name, got, want);
    abort_run();
  endtask

  // reference model that also queues the expected retirement
  task automatic add_instr(input logic [31:0] w);
    logic [31:0]      a;
    logic [31:0]      b;
    logic [4:0]       sh;
    logic [31:0]      v;
    logic             writes;
    cpu_pkg::retire_t r;
    a      = model_regs[w[19:15]];
    b      = model_regs[w[14:10]];
    sh     = w[14:10];
    v      = '0;
    writes = 1'b1;
    case (w[30:25])
      cpu_pkg::TYPE_BASIC: begin
        case (w[4:0])
          cpu_pkg::ADD:   v = a + b;
          cpu_pkg::SUB:   v = a - b;
          cpu_pkg::AND:   v = a & b;
          cpu_pkg::OR:    v = a | b;
          cpu_pkg::XOR:   v = a ^ b;
          cpu_pkg::SLLI:  v = a << sh;
          cpu_pkg::SRLI: begin
            v = a >> sh;
            // shift by zero is the nop
            writes = (sh != 5'd0);
          end
          cpu_pkg::ROTRI: v = (a >> sh) | (a << (6'd32 - {1'b0, sh}));
          default:        writes = 1'b0;
        endcase
      end
      cpu_pkg::ADDI: v = a + {{17{w[14]}}, w[14:0]};
      cpu_pkg::ORI:  v = a | {17'd0, w[14:0]};
      cpu_pkg::XORI: v = a ^ {17'd0, w[14:0]};
      cpu_pkg::MOVI: v = {{12{w[19]}}, w[19:0]};
      default:       writes = 1'b0;
    endcase
    if (writes) begin
      model_regs[w[24:20]] = v;
      r.valid = 1'b1;
      r.pc    = model_pc;
      r.rd    = w[24:20];
      r.value = v;
      expected.push_back(r);
    end
    prog.push_back(w);
    model_pc = model_pc + 1'b1;
  endtask

  task automatic add_random_instr();
    logic [4:0] rd;
    logic [4:0] ra;
    rnd = $random(seed);
    rd  = rnd[24:20];
    ra  = rnd[19:15];
    case (rnd[31:28])
      4'd0:    add_instr(basic_word(cpu_pkg::ADD, rd, ra, rnd[14:10]));
      4'd1:    add_instr(basic_word(cpu_pkg::SUB, rd, ra, rnd[14:10]));
      4'd2:    add_instr(basic_word(cpu_pkg::AND, rd, ra, rnd[14:10]));
      4'd3:    add_instr(basic_word(cpu_pkg::OR, rd, ra, rnd[14:10]));
      4'd4:    add_instr(basic_word(cpu_pkg::XOR, rd, ra, rnd[14:10]));
      4'd5:    add_instr(basic_word(cpu_pkg::SLLI, rd, ra, rnd[14:10]));
      4'd6:    add_instr(basic_word(cpu_pkg::SRLI, rd, ra, rnd[14:10]));
      4'd7:    add_instr(basic_word(cpu_pkg::ROTRI, rd, ra, rnd[14:10]));
      4'd8:    add_instr(imm_word(cpu_pkg::ADDI, rd, ra, rnd[14:0]));
      4'd9:    add_instr(imm_word(cpu_pkg::ORI, rd, ra, rnd[14:0]));
      4'd10:   add_instr(imm_word(cpu_pkg::XORI, rd, ra, rnd[14:0]));
      4'd11:   add_instr(movi_word(rd, rnd[19:0]));
      4'd12:   add_instr(imm_word(6'b111110, rd, ra, rnd[14:0]));
      4'd13:   add_instr(basic_word(5'b10101, rd, ra, rnd[14:10]));
      4'd14:   add_instr(imm_word(cpu_pkg::ADDI, rd, ra, rnd[14:0]));
      default: add_instr(basic_word(cpu_pkg::ROTRI, rd, ra, rnd[14:10]));
    endcase
  endtask

  initial begin
    load     = '0;
    seed     = 32'h5cc6951f;
    model_pc = '0;
    // every register gets a value before anything reads it
    add_instr(movi_word(5'd0, 20'h80001));
    add_instr(movi_word(5'd1, 20'h7fffe));
    for (int k = 2; k < N_INIT; k++) begin
      rnd = $random(seed);
      add_instr(movi_word(5'(k), rnd[19:0]));
    end
    for (int k = 0; k < N_RAND; k++) begin
      add_random_instr();
    end
    add_instr(basic_word(cpu_pkg::ADD, 5'd2, 5'd0, 5'd1));
    add_instr(basic_word(cpu_pkg::SUB, 5'd3, 5'd0, 5'd1));
    add_instr(basic_word(cpu_pkg::AND, 5'd4, 5'd0, 5'd1));
    add_instr(basic_word(cpu_pkg::OR, 5'd5, 5'd0, 5'd1));
    add_instr(basic_word(cpu_pkg::XOR, 5'd6, 5'd0, 5'd1));
    add_instr(basic_word(cpu_pkg::SLLI, 5'd7, 5'd0, 5'd3));
    add_instr(basic_word(cpu_pkg::SRLI, 5'd8, 5'd0, 5'd4));
    add_instr(basic_word(cpu_pkg::ROTRI, 5'd10, 5'd0, 5'd0));
    add_instr(basic_word(cpu_pkg::SRLI, 5'd11, 5'd2, 5'd0));
    add_instr(imm_word(cpu_pkg::ADDI, 5'd11, 5'd0, 15'h4000));
    add_instr(imm_word(cpu_pkg::ORI, 5'd12, 5'd1, 15'h7abc));
    add_instr(imm_word(cpu_pkg::XORI, 5'd13, 5'd0, 15'h4321));
    add_instr(imm_word(6'b111111, 5'd14, 5'd0, 15'h1234));
    add_instr(basic_word(5'b11111, 5'd14, 5'd0, 5'd1));
    add_instr(movi_word(5'd14, 20'h80000));
    add_instr(movi_word(5'd15, 20'h7ffff));
    // low bits of r15 are all ones, so they must land at the top
    add_instr(basic_word(cpu_pkg::ROTRI, 5'd9, 5'd15, 5'd7));
    add_instr(basic_word(cpu_pkg::ADD, 5'd16, 5'd14, 5'd15));
    add_instr(imm_word(cpu_pkg::ADDI, 5'd17, 5'd3, 15'h0010));

    // loading runs ahead of fetch once reset is released
    load_addr = '0;
    foreach (prog[i]) begin
      @(negedge clock);
      load.valid = 1'b1;
      load.addr  = load_addr;
      load.data  = prog[i];
      load_addr  = load_addr + 1'b1;
    end
    @(negedge clock);
    load = '0;

    while (expected.size() != 0) begin
      @(negedge clock);
    end
    $display("PASS: all tests");
    $finish;
  end

  // retire is stable away from the rising edge
  always @(negedge clock) begin
    if (retire.valid) begin
      assert (expected.size() != 0) else begin
        $display("retirement at pc %0h with no retirement left to expect", retire.pc);
        abort_run();
      end
      head = expected.pop_front();
      assert (retire.pc == head.pc)
        else report_mismatch("retire.pc", 32'(retire.pc), 32'(head.pc));
      assert (retire.rd == head.rd)
        else report_mismatch("retire.rd", 32'(retire.rd), 32'(head.rd));
      assert (retire.value == head.value)
        else report_mismatch("retire.value", retire.value, head.value);
    end
  end

  initial begin
    repeat (PROG_LEN * 4 + 50) @(posedge clock);
    $display("timeout: program did not finish within %0d cycles", PROG_LEN * 4 + 50);
    abort_run();
  end

endmodule
